/* source/rv_macros.svh */
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// data path and address width
`define RV_XLEN 32

// architectural register file
`define RV_NREGS 32
`define RV_REG_AW 5

// first fetch address after reset
`define RV_PC_RESET 32'h0000_0000

// fixed-size instructions, no compressed set
`define RV_INSN_BYTES 4

`endif

/* source/rv_pkg.sv */
`default_nettype none
`include "rv_macros.svh"

package rv_pkg;

  // major opcodes, RV32I base encoding
  typedef enum logic [6:0] {
    OPC_LOAD     = 7'b0000011,
    OPC_STORE    = 7'b0100011,
    OPC_BRANCH   = 7'b1100011,
    OPC_JALR     = 7'b1100111,
    OPC_MISC_MEM = 7'b0001111,
    OPC_JAL      = 7'b1101111,
    OPC_OP_IMM   = 7'b0010011,
    OPC_OP       = 7'b0110011,
    OPC_SYSTEM   = 7'b1110011,
    OPC_AUIPC    = 7'b0010111,
    OPC_LUI      = 7'b0110111
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
  } alu_op_e;

  // matches funct3[1:0] of loads and stores
  typedef enum logic [1:0] {
    MEM_BYTE = 2'b00,
    MEM_HALF = 2'b01,
    MEM_WORD = 2'b10
  } mem_size_e;

  typedef enum logic [1:0] {
    ST_FETCH, ST_EXECUTE, ST_LOAD_WAIT, ST_HALTED
  } core_state_e;

  typedef struct packed {
    logic [`RV_REG_AW-1:0] rs1;
    logic [`RV_REG_AW-1:0] rs2;
    logic [`RV_REG_AW-1:0] rd;
    logic [`RV_XLEN-1:0]   imm;
    alu_op_e               alu_op;
    // operand a is pc instead of rs1
    logic                  a_sel_pc;
    // operand b is imm instead of rs2
    logic                  b_sel_imm;
    logic [2:0]            funct3;
    logic                  reg_write;
    logic                  is_load;
    logic                  is_store;
    logic                  is_branch;
    logic                  is_jal;
    logic                  is_jalr;
    logic                  is_ecall;
    mem_size_e             mem_size;
    logic                  mem_unsigned;
  } decoded_t;

  typedef struct packed {
    logic [`RV_XLEN-1:0] addr;
    logic [`RV_XLEN-1:0] wdata;
    logic [3:0]          be;
    logic                read;
  } dmem_req_t;

  typedef struct packed {
    logic                  valid;
    logic [`RV_XLEN-1:0]   pc;
    logic [`RV_XLEN-1:0]   insn;
    logic                  rd_we;
    logic [`RV_REG_AW-1:0] rd;
    logic [`RV_XLEN-1:0]   rd_data;
  } retire_t;

endpackage

`default_nettype wire

/* source/rv_decoder.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_macros.svh"

module rv_decoder
  import rv_pkg::*;
(
  input  logic [`RV_XLEN-1:0] insn,
  output decoded_t            dec
);

  opcode_e             opcode;
  logic [6:0]          funct7;
  logic [2:0]          funct3;
  logic                alt;
  logic                legal;
  logic [`RV_XLEN-1:0] imm_i;
  logic [`RV_XLEN-1:0] imm_s;
  logic [`RV_XLEN-1:0] imm_b;
  logic [`RV_XLEN-1:0] imm_j;
  logic [`RV_XLEN-1:0] imm_u;

  assign opcode = opcode_e'(insn[6:0]);
  assign funct7 = insn[31:25];
  assign funct3 = insn[14:12];
  // sub / sra select
  assign alt    = (funct7 == 7'b0100000);

  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
  assign imm_b = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_j = {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};
  assign imm_u = {insn[31:12], 12'b0};

  // shared by OP and OP_IMM
  function automatic alu_op_e alu_from_funct3(input logic [2:0] f3, input logic sub_sra);
    case (f3)
      3'b000:  return sub_sra ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return sub_sra ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  always_comb begin
    dec              = '0;
    legal            = 1'b1;
    dec.rs1          = insn[19:15];
    dec.rs2          = insn[24:20];
    dec.rd           = insn[11:7];
    dec.funct3       = funct3;
    dec.alu_op       = ALU_ADD;
    dec.mem_size     = mem_size_e'(funct3[1:0]);
    dec.mem_unsigned = funct3[2];
    case (opcode)
      OPC_LUI: begin
        dec.imm       = imm_u;
        dec.alu_op    = ALU_PASS_B;
        dec.b_sel_imm = 1'b1;
        dec.reg_write = 1'b1;
      end
      OPC_AUIPC: begin
        dec.imm       = imm_u;
        dec.a_sel_pc  = 1'b1;
        dec.b_sel_imm = 1'b1;
        dec.reg_write = 1'b1;
      end
      OPC_JAL: begin
        dec.imm       = imm_j;
        dec.is_jal    = 1'b1;
        dec.reg_write = 1'b1;
      end
      OPC_JALR: begin
        dec.imm       = imm_i;
        dec.b_sel_imm = 1'b1;
        dec.is_jalr   = 1'b1;
        dec.reg_write = 1'b1;
        legal         = (funct3 == 3'b000);
      end
      OPC_BRANCH: begin
        dec.imm       = imm_b;
        dec.is_branch = 1'b1;
        legal         = (funct3[2:1] != 2'b01);
      end
      OPC_LOAD: begin
        dec.imm       = imm_i;
        dec.b_sel_imm = 1'b1;
        dec.is_load   = 1'b1;
        dec.reg_write = 1'b1;
        // lb lh lw lbu lhu
        legal         = (funct3[1:0] != 2'b11) && (funct3 != 3'b110);
      end
      OPC_STORE: begin
        dec.imm       = imm_s;
        dec.b_sel_imm = 1'b1;
        dec.is_store  = 1'b1;
        legal         = (funct3[2] == 1'b0) && (funct3[1:0] != 2'b11);
      end
      OPC_OP_IMM: begin
        dec.imm       = imm_i;
        dec.b_sel_imm = 1'b1;
        dec.reg_write = 1'b1;
        // addi never subtracts, only srai uses the alt bit
        dec.alu_op    = alu_from_funct3(funct3, alt && funct3 == 3'b101);
        if (funct3 == 3'b001) begin
          legal = (funct7 == 7'd0);
        end else if (funct3 == 3'b101) begin
          legal = (funct7 == 7'd0) || alt;
        end
      end
      OPC_OP: begin
        dec.reg_write = 1'b1;
        dec.alu_op    = alu_from_funct3(funct3, alt);
        legal         = (funct7 == 7'd0) || (alt && (funct3 == 3'b000 || funct3 == 3'b101));
      end
      OPC_SYSTEM: begin
        // only ecall acts, other system encodings retire as no-ops
        dec.is_ecall = (insn[31:7] == 25'd0);
      end
      OPC_MISC_MEM: begin
      end
      default: begin
        legal = 1'b0;
      end
    endcase
    if (!legal) begin
      dec.reg_write = 1'b0;
      dec.is_load   = 1'b0;
      dec.is_store  = 1'b0;
      dec.is_branch = 1'b0;
      dec.is_jal    = 1'b0;
      dec.is_jalr   = 1'b0;
      dec.is_ecall  = 1'b0;
    end
  end

endmodule

`default_nettype wire

/* source/rv_regfile.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_macros.svh"

module rv_regfile (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [`RV_REG_AW-1:0] rs1,
  input  logic [`RV_REG_AW-1:0] rs2,
  input  logic [`RV_REG_AW-1:0] rd,
  input  logic                  we,
  input  logic [`RV_XLEN-1:0]   rd_data,
  output logic [`RV_XLEN-1:0]   rs1_data,
  output logic [`RV_XLEN-1:0]   rs2_data
);

  // x0 has no storage
  logic [`RV_XLEN-1:0] regs [1:`RV_NREGS-1];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < `RV_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin
      regs[rd] <= rd_data;
    end
  end

  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

/* source/rv_alu.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_macros.svh"

module rv_alu
  import rv_pkg::*;
(
  input  decoded_t            dec,
  input  logic [`RV_XLEN-1:0] pc,
  input  logic [`RV_XLEN-1:0] rs1_data,
  input  logic [`RV_XLEN-1:0] rs2_data,
  output logic [`RV_XLEN-1:0] result,
  output logic                branch_taken
);

  logic [`RV_XLEN-1:0] op_a;
  logic [`RV_XLEN-1:0] op_b;
  logic [4:0]          shamt;
  logic                cond;

  assign op_a  = dec.a_sel_pc ? pc : rs1_data;
  assign op_b  = dec.b_sel_imm ? dec.imm : rs2_data;
  assign shamt = op_b[4:0];

  always_comb begin
    case (dec.alu_op)
      ALU_ADD:    result = op_a + op_b;
      ALU_SUB:    result = op_a - op_b;
      ALU_SLL:    result = op_a << shamt;
      ALU_SLT:    result = {31'd0, $signed(op_a) < $signed(op_b)};
      ALU_SLTU:   result = {31'd0, op_a < op_b};
      ALU_XOR:    result = op_a ^ op_b;
      ALU_SRL:    result = op_a >> shamt;
      ALU_SRA:    result = $unsigned($signed(op_a) >>> shamt);
      ALU_OR:     result = op_a | op_b;
      ALU_AND:    result = op_a & op_b;
      ALU_PASS_B: result = op_b;
      default:    result = '0;
    endcase
  end

  // compare always uses both registers
  always_comb begin
    case (dec.funct3)
      3'b000:  cond = (rs1_data == rs2_data);
      3'b001:  cond = (rs1_data != rs2_data);
      3'b100:  cond = ($signed(rs1_data) < $signed(rs2_data));
      3'b101:  cond = ($signed(rs1_data) >= $signed(rs2_data));
      3'b110:  cond = (rs1_data < rs2_data);
      3'b111:  cond = (rs1_data >= rs2_data);
      default: cond = 1'b0;
    endcase
  end

  assign branch_taken = dec.is_branch & cond;

endmodule

`default_nettype wire

/* source/rv_lsu.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_macros.svh"

module rv_lsu
  import rv_pkg::*;
(
  input  decoded_t            dec,
  input  logic [`RV_XLEN-1:0] addr,
  input  logic [`RV_XLEN-1:0] store_data,
  input  logic                store_en,
  input  logic [`RV_XLEN-1:0] load_data,
  output dmem_req_t           req,
  output logic [`RV_XLEN-1:0] load_value
);

  logic [1:0]          lane;
  logic [`RV_XLEN-1:0] lane_data;
  logic                sext;

  // the core holds insn and registers through the load wait cycle,
  // so addr still carries the request-cycle offset here
  assign lane = addr[1:0];

  always_comb begin
    req       = '0;
    req.addr  = {addr[`RV_XLEN-1:2], 2'b00};
    req.wdata = store_data << {lane, 3'b000};
    case (dec.mem_size)
      MEM_BYTE: req.be = 4'b0001 << lane;
      MEM_HALF: req.be = lane[1] ? 4'b1100 : 4'b0011;
      default: begin
        req.wdata = store_data;
        req.be    = 4'b1111;
      end
    endcase
    // strobes only in the execute cycle
    if (!(store_en && dec.is_store)) begin
      req.be = 4'b0000;
    end
    req.read = store_en & dec.is_load;
  end

  assign lane_data = load_data >> {lane, 3'b000};
  assign sext      = ~dec.mem_unsigned;

  always_comb begin
    case (dec.mem_size)
      MEM_BYTE: load_value = {{24{sext & lane_data[7]}}, lane_data[7:0]};
      MEM_HALF: load_value = {{16{sext & lane_data[15]}}, lane_data[15:0]};
      default:  load_value = load_data;
    endcase
  end

endmodule

`default_nettype wire

/* source/rv_core.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_macros.svh"

module rv_core
  import rv_pkg::*;
(
  input  logic                clk,
  input  logic                rst,
  output logic [`RV_XLEN-1:0] imem_addr,
  input  logic [`RV_XLEN-1:0] insn,
  output dmem_req_t           dmem_req,
  input  logic [`RV_XLEN-1:0] load_data,
  output logic                halt,
  output retire_t             retire
);

  core_state_e         state;
  logic [`RV_XLEN-1:0] pc;
  logic [`RV_XLEN-1:0] insn_q;
  logic [`RV_XLEN-1:0] cur_insn;
  decoded_t            dec;
  logic [`RV_XLEN-1:0] rs1_data;
  logic [`RV_XLEN-1:0] rs2_data;
  logic [`RV_XLEN-1:0] alu_result;
  logic                branch_taken;
  logic [`RV_XLEN-1:0] load_value;
  logic [`RV_XLEN-1:0] pc_plus4;
  logic [`RV_XLEN-1:0] next_pc;
  logic [`RV_XLEN-1:0] wb_data;
  logic                wb_we;
  logic                retire_fire;

  // imem data is live in execute, held copy during load wait
  assign cur_insn = (state == ST_EXECUTE) ? insn : insn_q;

  rv_decoder u_decoder (
    .insn (cur_insn),
    .dec  (dec)
  );

  rv_regfile u_regfile (
    .clk      (clk),
    .rst      (rst),
    .rs1      (dec.rs1),
    .rs2      (dec.rs2),
    .rd       (dec.rd),
    .we       (wb_we),
    .rd_data  (wb_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  rv_alu u_alu (
    .dec          (dec),
    .pc           (pc),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data),
    .result       (alu_result),
    .branch_taken (branch_taken)
  );

  rv_lsu u_lsu (
    .dec        (dec),
    .addr       (alu_result),
    .store_data (rs2_data),
    .store_en   (state == ST_EXECUTE),
    .load_data  (load_data),
    .req        (dmem_req),
    .load_value (load_value)
  );

  assign retire_fire = (state == ST_EXECUTE && !dec.is_load) || (state == ST_LOAD_WAIT);

  assign pc_plus4 = pc + `RV_INSN_BYTES;

  always_comb begin
    if (dec.is_jal || branch_taken) begin
      next_pc = pc + dec.imm;
    end else if (dec.is_jalr) begin
      next_pc = {alu_result[`RV_XLEN-1:1], 1'b0};
    end else begin
      next_pc = pc_plus4;
    end
  end

  // link value for jumps
  assign wb_data = (dec.is_jal || dec.is_jalr) ? pc_plus4 :
                   dec.is_load ? load_value : alu_result;
  assign wb_we   = retire_fire && dec.reg_write && (dec.rd != '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_FETCH;
      pc    <= `RV_PC_RESET;
    end else begin
      case (state)
        ST_FETCH: state <= ST_EXECUTE;
        ST_EXECUTE: begin
          if (dec.is_load) begin
            state <= ST_LOAD_WAIT;
          end else begin
            state <= dec.is_ecall ? ST_HALTED : ST_FETCH;
            pc    <= next_pc;
          end
        end
        ST_LOAD_WAIT: begin
          state <= ST_FETCH;
          pc    <= next_pc;
        end
        default: state <= ST_HALTED;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == ST_EXECUTE) begin
      insn_q <= insn;
    end
  end

  assign imem_addr = pc;
  assign halt      = (state == ST_HALTED);

  always_comb begin
    retire.valid   = retire_fire;
    retire.pc      = pc;
    retire.insn    = cur_insn;
    retire.rd_we   = wb_we;
    retire.rd      = dec.rd;
    retire.rd_data = wb_we ? wb_data : '0;
  end

endmodule

`default_nettype wire

/* sim/rv_ref_model.svh */
`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH

// architectural state, one instruction per step
logic [`RV_XLEN-1:0] model_regs [0:`RV_NREGS-1];
logic [`RV_XLEN-1:0] model_pc;
logic [`RV_XLEN-1:0] model_dmem [0:DMEM_WORDS-1];

// rv32i integer ops, alt selects sub and sra
function automatic logic [31:0] alu_result(input logic [2:0] f3, input logic alt,
                                           input logic [31:0] a, input logic [31:0] b);
  case (f3)
    3'b000:  return alt ? a - b : a + b;
    3'b001:  return a << b[4:0];
    3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    3'b011:  return (a < b) ? 32'd1 : 32'd0;
    3'b100:  return a ^ b;
    3'b101:  return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
    3'b110:  return a | b;
    default: return a & b;
  endcase
endfunction

function automatic logic take_branch(input logic [2:0] f3, input logic [31:0] a,
                                     input logic [31:0] b);
  case (f3)
    3'b000:  return a == b;
    3'b001:  return a != b;
    3'b100:  return $signed(a) < $signed(b);
    3'b101:  return $signed(a) >= $signed(b);
    3'b110:  return a < b;
    default: return a >= b;
  endcase
endfunction

task automatic reset_model();
  model_pc = `RV_PC_RESET;
  for (int r = 0; r < `RV_NREGS; r++) begin
    model_regs[r] = '0;
  end
  for (int i = 0; i < DMEM_WORDS; i++) begin
    model_dmem[i] = fill_word(i);
  end
endtask

// predicts the retire record and the memory request of the next instruction
task automatic step_instruction(output retire_t ret, output dmem_req_t req,
                                output logic is_load, output logic is_halt);
  logic [31:0] in;
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] res;
  logic [31:0] addr;
  logic [31:0] word;
  logic [31:0] npc;
  logic [31:0] imm_i;
  logic [31:0] imm_s;
  logic [31:0] imm_b;
  logic [31:0] imm_j;
  logic        we;
  in    = imem[model_pc[7:2]];
  a     = model_regs[in[19:15]];
  b     = model_regs[in[24:20]];
  imm_i = {{20{in[31]}}, in[31:20]};
  imm_s = {{20{in[31]}}, in[31:25], in[11:7]};
  imm_b = {{20{in[31]}}, in[7], in[30:25], in[11:8], 1'b0};
  imm_j = {{12{in[31]}}, in[19:12], in[20], in[30:21], 1'b0};
  res     = '0;
  we      = 1'b0;
  npc     = model_pc + 32'd4;
  req     = '0;
  is_load = 1'b0;
  is_halt = 1'b0;
  case (in[6:0])
    7'b0110111: begin
      res = {in[31:12], 12'b0};
      we  = 1'b1;
    end
    7'b0010111: begin
      res = model_pc + {in[31:12], 12'b0};
      we  = 1'b1;
    end
    7'b1101111: begin
      res = model_pc + 32'd4;
      we  = 1'b1;
      npc = model_pc + imm_j;
    end
    7'b1100111: begin
      res = model_pc + 32'd4;
      we  = 1'b1;
      npc = (a + imm_i) & ~32'd1;
    end
    7'b1100011: begin
      if (take_branch(in[14:12], a, b)) begin
        npc = model_pc + imm_b;
      end
    end
    7'b0000011: begin
      addr     = a + imm_i;
      word     = model_dmem[addr[7:2]] >> {addr[1:0], 3'b000};
      we       = 1'b1;
      is_load  = 1'b1;
      req.addr = {addr[31:2], 2'b00};
      req.read = 1'b1;
      case (in[14:12])
        3'b000:  res = {{24{word[7]}}, word[7:0]};
        3'b001:  res = {{16{word[15]}}, word[15:0]};
        3'b100:  res = {24'd0, word[7:0]};
        3'b101:  res = {16'd0, word[15:0]};
        default: res = word;
      endcase
    end
    7'b0100011: begin
      addr      = a + imm_s;
      req.addr  = {addr[31:2], 2'b00};
      req.wdata = b << {addr[1:0], 3'b000};
      case (in[13:12])
        2'b00:   req.be = 4'b0001 << addr[1:0];
        2'b01:   req.be = 4'b0011 << addr[1:0];
        default: req.be = 4'b1111;
      endcase
      for (int k = 0; k < 4; k++) begin
        if (req.be[k]) begin
          model_dmem[addr[7:2]][8*k +: 8] = req.wdata[8*k +: 8];
        end
      end
    end
    7'b0010011: begin
      // only srai takes the alt bit
      res = alu_result(in[14:12], in[30] && in[14:12] == 3'b101, a, imm_i);
      we  = 1'b1;
    end
    7'b0110011: begin
      res = alu_result(in[14:12], in[30], a, b);
      we  = 1'b1;
    end
    7'b1110011: begin
      is_halt = (in == 32'h0000_0073);
    end
    default: begin
    end
  endcase
  ret.valid   = 1'b1;
  ret.pc      = model_pc;
  ret.insn    = in;
  ret.rd_we   = we && (in[11:7] != 5'd0);
  ret.rd      = in[11:7];
  ret.rd_data = ret.rd_we ? res : '0;
  if (ret.rd_we) begin
    model_regs[in[11:7]] = res;
  end
  model_pc = npc;
endtask

`endif

/* sim/tb_rv_core.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_macros.svh"

module tb_rv_core
  import rv_pkg::*;
();

  localparam int CLK_PERIOD  = 40;
  localparam int NUM_PROGS   = 12;
  localparam int PROG_LEN    = 64;
  localparam int DMEM_WORDS  = 64;
  localparam int WATCHDOG_NS = NUM_PROGS * PROG_LEN * 3 * CLK_PERIOD
                               + NUM_PROGS * 24 * CLK_PERIOD;

  logic                clk       = 1'b0;
  logic                rst       = 1'b1;
  logic [`RV_XLEN-1:0] insn      = '0;
  logic [`RV_XLEN-1:0] load_data = '0;
  logic [`RV_XLEN-1:0] imem_addr;
  dmem_req_t           dmem_req;
  logic                halt;
  retire_t             retire;

  logic [31:0] imem [0:PROG_LEN-1];
  logic [31:0] dmem [0:DMEM_WORDS-1];

  // data area contents, a function of the word address
  function automatic logic [31:0] fill_word(input int i);
    return (32'(i) * 32'h9e37_79b9) ^ {16'(i), 16'hc3a5};
  endfunction

  `include "rv_ref_model.svh"

  rv_core dut0 (
    .clk       (clk),
    .rst       (rst),
    .imem_addr (imem_addr),
    .insn      (insn),
    .dmem_req  (dmem_req),
    .load_data (load_data),
    .halt      (halt),
    .retire    (retire)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // synchronous imem, read-first dmem with byte writes
  always @(posedge clk) begin
    insn <= imem[imem_addr[7:2]];
    if (rst) begin
      for (int i = 0; i < DMEM_WORDS; i++) begin
        dmem[i] <= fill_word(i);
      end
    end else begin
      if (dmem_req.read) begin
        load_data <= dmem[dmem_req.addr[7:2]];
      end
      for (int b = 0; b < 4; b++) begin
        if (dmem_req.be[b]) begin
          dmem[dmem_req.addr[7:2]][8*b +: 8] <= dmem_req.wdata[8*b +: 8];
        end
      end
    end
  end

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [6:0] op);
    return {f7, rs2, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                         input logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  // x1 stays the data base, results go to x2..x11 or now and then x0
  function automatic logic [31:0] random_insn(input int idx);
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [11:0] off;
    logic [31:0] w;
    int          skip;
    rd   = ($urandom_range(7) == 0) ? 5'd0 : 5'($urandom_range(11, 2));
    rs1  = 5'($urandom_range(11));
    rs2  = 5'($urandom_range(11));
    f3   = 3'($urandom_range(7));
    f7   = ($urandom_range(1) == 1) ? 7'h20 : 7'h00;
    off  = 12'($urandom_range(127)) - 12'd64;
    // forward only, never past the final ecall
    skip = int'($urandom_range(3, 1));
    if (idx + skip > PROG_LEN - 1) begin
      skip = PROG_LEN - 1 - idx;
    end
    case ($urandom_range(11))
      0, 1, 2: begin
        if (f3 != 3'b000 && f3 != 3'b101) begin
          f7 = 7'h00;
        end
        w = r_type(f7, rs2, rs1, f3, rd, OPC_OP);
      end
      3, 4, 5: begin
        if (f3 == 3'b001) begin
          f7 = 7'h00;
        end
        if (f3[1:0] == 2'b01) begin
          w = i_type({f7, rs2}, rs1, f3, rd, OPC_OP_IMM);
        end else begin
          w = i_type(12'($urandom), rs1, f3, rd, OPC_OP_IMM);
        end
      end
      6: w = u_type(20'($urandom), rd, ($urandom_range(1) == 1) ? OPC_LUI : OPC_AUIPC);
      7: begin
        if ($urandom_range(1) == 1) begin
          w = j_type(21'(skip * 4), rd);
        end else begin
          w = i_type(12'((idx + skip) * 4), 5'd0, 3'b000, rd, OPC_JALR);
        end
      end
      8: begin
        // funct3 2 and 3 are not branches
        if (f3[2:1] == 2'b01) begin
          f3[2] = 1'b1;
        end
        w = b_type(13'(skip * 4), rs2, rs1, f3);
      end
      9, 10: begin
        if ($urandom_range(1) == 1) begin
          f3 = 3'($urandom_range(4));
          if (f3 >= 3'd3) begin
            f3 = f3 + 3'd1;
          end
        end else begin
          f3 = 3'($urandom_range(2));
        end
        // natural alignment for the access size
        if (f3[1:0] == 2'b01) begin
          off[0] = 1'b0;
        end else if (f3[1:0] == 2'b10) begin
          off[1:0] = 2'b00;
        end
        if (f3 >= 3'd4 || $urandom_range(1) == 1) begin
          w = i_type(off, 5'd1, f3, rd, OPC_LOAD);
        end else begin
          w = s_type(off, rs2, 5'd1, f3);
        end
      end
      default: w = 32'h0ff0_000f;
    endcase
    return w;
  endfunction

  task automatic build_program();
    int n;
    imem[0] = i_type(12'h080, 5'd0, 3'b000, 5'd1, OPC_OP_IMM);
    n = 1;
    for (int r = 2; r < 12; r++) begin
      imem[n]     = u_type(20'($urandom), 5'(r), OPC_LUI);
      imem[n + 1] = i_type(12'($urandom), 5'(r), 3'b000, 5'(r), OPC_OP_IMM);
      n = n + 2;
    end
    for (int i = n; i < PROG_LEN - 1; i++) begin
      imem[i] = random_insn(i);
    end
    imem[PROG_LEN - 1] = 32'h0000_0073;
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("CHECK FAILED at %0d ns: %s expected %h actual %h", $time, name, exp, act);
    $display("sim failed");
    $fatal(1, "first mismatch");
  endtask

  task automatic compare_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      report_mismatch(name, 32'(exp), 32'(act));
    end
  endtask

  task automatic compare_word(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
    if (act !== exp) begin
      report_mismatch(name, exp, act);
    end
  endtask

  task automatic check_retire(input retire_t exp, input retire_t act);
    compare_flag("retire.valid", exp.valid, act.valid);
    compare_word("retire.pc", exp.pc, act.pc);
    compare_word("retire.insn", exp.insn, act.insn);
    compare_flag("retire.rd_we", exp.rd_we, act.rd_we);
    if (exp.rd_we) begin
      compare_word("retire.rd", 32'(exp.rd), 32'(act.rd));
      compare_word("retire.rd_data", exp.rd_data, act.rd_data);
    end
  endtask

  // disabled byte lanes carry no meaning
  task automatic check_dmem_req(input dmem_req_t exp, input dmem_req_t act);
    logic [31:0] mask;
    mask = {{8{exp.be[3]}}, {8{exp.be[2]}}, {8{exp.be[1]}}, {8{exp.be[0]}}};
    compare_word("dmem_req.be", 32'(exp.be), 32'(act.be));
    compare_flag("dmem_req.read", exp.read, act.read);
    if (exp.be != 4'b0000 || exp.read) begin
      compare_word("dmem_req.addr", exp.addr, act.addr);
    end
    compare_word("dmem_req.wdata", exp.wdata & mask, act.wdata & mask);
  endtask

  initial begin
    retire_t     exp_ret;
    dmem_req_t   exp_req;
    dmem_req_t   idle_req;
    logic        exp_load;
    logic        exp_halt;
    int unsigned seed;
    idle_req = '0;
    seed     = $urandom(34715);
    for (int p = 0; p < NUM_PROGS; p++) begin
      @(posedge clk);
      rst <= 1'b1;
      @(negedge clk);
      build_program();
      reset_model();
      repeat (3) @(posedge clk);
      @(posedge clk);
      rst <= 1'b0;
      exp_halt = 1'b0;
      while (!exp_halt) begin
        step_instruction(exp_ret, exp_req, exp_load, exp_halt);
        // fetch
        @(negedge clk);
        compare_word("imem_addr", exp_ret.pc, imem_addr);
        compare_flag("halt", 1'b0, halt);
        compare_flag("retire.valid", 1'b0, retire.valid);
        check_dmem_req(idle_req, dmem_req);
        // execute
        @(negedge clk);
        check_dmem_req(exp_req, dmem_req);
        if (exp_load) begin
          compare_flag("retire.valid", 1'b0, retire.valid);
          @(negedge clk);
          check_dmem_req(idle_req, dmem_req);
        end
        check_retire(exp_ret, retire);
        compare_flag("halt", 1'b0, halt);
      end
      // after ecall nothing may leave the core
      repeat (8) begin
        @(negedge clk);
        compare_flag("halt", 1'b1, halt);
        compare_flag("retire.valid", 1'b0, retire.valid);
        check_dmem_req(idle_req, dmem_req);
      end
    end
    $display("sim passed");
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired, the core did not finish its programs in time");
    $display("sim failed");
    $fatal(1, "timeout");
  end

endmodule

`default_nettype wire

/* build.f */
+incdir+source
+incdir+sim
source/rv_pkg.sv
source/rv_decoder.sv
source/rv_regfile.sv
source/rv_alu.sv
source/rv_lsu.sv
source/rv_core.sv
sim/tb_rv_core.sv

/* run_sim.sh */
#!/bin/sh
# build and run the rv_core testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f build.f --top-module tb_rv_core -o tb_rv_core
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/tb_rv_core
status=$?
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit "$status"
fi
exit 0
